// File: Bender.yml
package:
  name: dm_cache

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cache_array_if.sv
      - design/mem_if.sv
      - design/cache_array.sv
      - design/main_mem.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/cache_tb.sv

// File: compile.f
+incdir+design
design/cache_pkg.sv
design/cache_array_if.sv
design/mem_if.sv
design/cache_array.sv
design/main_mem.sv
design/cache_ctrl.sv
design/cache_top.sv
verification/cache_tb.sv

// File: design/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

// Register array shared by the tag store and the data store
module cache_array
    import cache_pkg::*;
#(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 256
) (
    input wire           clk,
    input wire           rst_n,
    cache_array_if.array bus
);

    entry_t entries [DEPTH];

    // Read path has no register
    assign bus.rdata = entries[bus.addr];

    // Write lands at the clock edge
    // Cleared on reset so every tag entry starts invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (bus.we) begin
            entries[bus.addr] <= bus.wdata;
        end
    end

endmodule

`default_nettype wire

// File: design/cache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

// One port of a cache storage array
interface cache_array_if #(
    parameter type entry_t = logic,
    parameter int  ADDR_W  = 8
);

    logic [ADDR_W-1:0] addr;
    logic              we;
    entry_t            wdata;
    // Combinational read of the entry at addr
    entry_t            rdata;

    // Controller side
    modport ctrl (output addr, output we, output wdata, input rdata);

    // Storage side
    modport array (input addr, input we, input wdata, output rdata);

endinterface

`default_nettype wire

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// Direct mapped write-back cache controller
module cache_ctrl
    import cache_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     rd,
    input  wire                     wr,
    input  wire [`CACHE_ADDR_W-1:0] addr,
    input  word_t                   wdata,
    output word_t                   rdata,
    output logic                    done,
    output logic                    stall,
    output logic                    cache_hit,
    cache_array_if.ctrl             tag,
    cache_array_if.ctrl             data,
    mem_if.master                   mem
);

    localparam int OFFSET_W   = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;
    localparam int WORD_SEL_W = $clog2(`CACHE_WORDS_PER_LINE);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic [`CACHE_TAG_W-1:0]   req_tag;
    logic [`CACHE_INDEX_W-1:0] req_index;
    logic [WORD_SEL_W-1:0]     req_word;
    logic                      req;
    logic                      hit;

    // Word numbers taken from the position inside each state run
    logic [WORD_SEL_W-1:0] wb_word;
    logic [WORD_SEL_W-1:0] fill_rd_word;
    logic [WORD_SEL_W-1:0] fill_wr_word;

    // Address split with byte bit 0 dropped
    assign req_tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index = addr[OFFSET_W +: `CACHE_INDEX_W];
    assign req_word  = addr[1 +: WORD_SEL_W];

    assign req = rd | wr;

    // Tag compare on the entry at the request index
    assign hit = req & tag.rdata.valid & (tag.rdata.tag == req_tag);

    // Only a request completing from idle counts as a hit
    assign cache_hit = (state_q == st_idle) & hit;

    assign wb_word      = WORD_SEL_W'(state_q - st_write_back_0);
    assign fill_rd_word = WORD_SEL_W'(state_q - st_fill_0);
    assign fill_wr_word = WORD_SEL_W'(state_q - st_fill_2);

    // Host read data is valid whenever the data array points at the host word
    assign rdata = data.rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        done    = 1'b0;
        stall   = 1'b1;

        // Arrays default to the host line and word
        tag.addr        = req_index;
        tag.we          = 1'b0;
        tag.wdata       = '0;
        tag.wdata.valid = 1'b1;
        tag.wdata.tag   = req_tag;
        data.addr       = {req_index, req_word};
        data.we         = 1'b0;
        data.wdata      = wdata;

        // Memory idle by default with write data always from the data array
        mem.addr  = {req_tag, req_index, req_word};
        mem.wdata = data.rdata;
        mem.rd    = 1'b0;
        mem.wr    = 1'b0;

        case (state_q)
            st_idle: begin
                stall = 1'b0;
                if (hit) begin
                    done = 1'b1;
                    // Write hit updates the word and marks the line dirty
                    data.we         = wr;
                    tag.we          = wr;
                    tag.wdata.dirty = 1'b1;
                end else if (req) begin
                    state_d = (tag.rdata.valid && tag.rdata.dirty) ? st_write_back_0
                                                                   : st_fill_0;
                end
            end

            st_write_back_0, st_write_back_1, st_write_back_2, st_write_back_3: begin
                // Victim word goes out under the tag still in the store
                data.addr = {req_index, wb_word};
                mem.wr    = 1'b1;
                mem.addr  = {tag.rdata.tag, req_index, wb_word};
                // Last write-back word runs straight on into fill_0
                state_d   = ctrl_state_t'(state_q + 4'd1);
            end

            st_fill_0, st_fill_1: begin
                mem.rd   = 1'b1;
                mem.addr = {req_tag, req_index, fill_rd_word};
                state_d  = ctrl_state_t'(state_q + 4'd1);
            end

            st_fill_2, st_fill_3: begin
                // Reads still issuing while earlier words return
                mem.rd     = 1'b1;
                mem.addr   = {req_tag, req_index, fill_rd_word};
                data.we    = 1'b1;
                data.addr  = {req_index, fill_wr_word};
                data.wdata = mem.rdata;
                state_d    = ctrl_state_t'(state_q + 4'd1);
            end

            st_fill_4: begin
                data.we    = 1'b1;
                data.addr  = {req_index, fill_wr_word};
                data.wdata = mem.rdata;
                state_d    = st_fill_5;
            end

            st_fill_5: begin
                // Last word in and the line now valid and clean under the new tag
                data.we    = 1'b1;
                data.addr  = {req_index, fill_wr_word};
                data.wdata = mem.rdata;
                tag.we     = 1'b1;
                state_d    = wr ? st_cwrite : st_done;
            end

            st_cwrite: begin
                // Host word into the fresh line
                data.we         = 1'b1;
                tag.we          = 1'b1;
                tag.wdata.dirty = 1'b1;
                state_d         = st_done;
            end

            st_done: begin
                done    = 1'b1;
                state_d = st_idle;
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address into the 64 KB host space
`define CACHE_ADDR_W 16

// Host and memory word width
`define CACHE_WORD_W 16

// Address split: tag, index, then 3-bit byte offset
`define CACHE_TAG_W 5
`define CACHE_INDEX_W 8

// Direct mapped, one line per index
`define CACHE_LINES 256
`define CACHE_WORDS_PER_LINE 4

// Cycles from a main memory read strobe to its data
`define CACHE_MEM_LATENCY 2

`endif

// File: design/cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    // One host or memory word
    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // Tag store entry, all zero means an empty line
    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`CACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // Controller states
    // Values are contiguous, the controller derives word numbers from them
    typedef enum logic [3:0] {
        st_idle         = 4'd0,
        st_write_back_0 = 4'd1,
        st_write_back_1 = 4'd2,
        st_write_back_2 = 4'd3,
        st_write_back_3 = 4'd4,
        st_fill_0       = 4'd5,
        st_fill_1       = 4'd6,
        st_fill_2       = 4'd7,
        st_fill_3       = 4'd8,
        st_fill_4       = 4'd9,
        st_fill_5       = 4'd10,
        st_cwrite       = 4'd11,
        st_done         = 4'd12
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// Cache with its two stores and the main memory model
module cache_top
    import cache_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     rd,
    input  wire                     wr,
    input  wire [`CACHE_ADDR_W-1:0] addr,
    input  word_t                   wdata,
    output word_t                   rdata,
    output logic                    done,
    output logic                    stall,
    output logic                    cache_hit
);

    localparam int WORD_SEL_W = $clog2(`CACHE_WORDS_PER_LINE);
    localparam int DATA_DEPTH = `CACHE_LINES * `CACHE_WORDS_PER_LINE;

    // Tag store port, one entry per line
    cache_array_if #(
        .entry_t (tag_entry_t),
        .ADDR_W  (`CACHE_INDEX_W)
    ) tag_if ();

    // Data store port, index joined with word number
    cache_array_if #(
        .entry_t (word_t),
        .ADDR_W  (`CACHE_INDEX_W + WORD_SEL_W)
    ) data_if ();

    mem_if mem_bus ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit),
        .tag       (tag_if.ctrl),
        .data      (data_if.ctrl),
        .mem       (mem_bus.master)
    );

    cache_array #(
        .entry_t (tag_entry_t),
        .DEPTH   (`CACHE_LINES)
    ) u_tag_store (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tag_if.array)
    );

    cache_array #(
        .entry_t (word_t),
        .DEPTH   (DATA_DEPTH)
    ) u_data_store (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (data_if.array)
    );

    main_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.slave)
    );

endmodule

`default_nettype wire

// File: design/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// Main memory model with fixed read latency and no back-pressure
module main_mem
    import cache_pkg::*;
(
    input wire    clk,
    input wire    rst_n,
    mem_if.slave  bus
);

    localparam int WADDR_W   = `CACHE_ADDR_W - 1;
    localparam int MEM_WORDS = 1 << WADDR_W;
    localparam int LAT       = `CACHE_MEM_LATENCY;

    // Backing store, zero at start
    word_t store [MEM_WORDS] = '{default: '0};

    // Read pipeline, one slot per cycle of latency
    logic [WADDR_W-1:0] rd_addr_q [LAT];
    logic [LAT-1:0]     rd_vld_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= '0;
            for (int i = 0; i < LAT; i++) begin
                rd_addr_q[i] <= '0;
            end
        end else begin
            // New read enters slot 0, older ones shift along
            rd_vld_q[0]  <= bus.rd;
            rd_addr_q[0] <= bus.addr;
            for (int i = 1; i < LAT; i++) begin
                rd_vld_q[i]  <= rd_vld_q[i-1];
                rd_addr_q[i] <= rd_addr_q[i-1];
            end
        end
    end

    // Writes take effect at the edge of the strobe
    always_ff @(posedge clk) begin
        if (bus.wr) begin
            store[bus.addr] <= bus.wdata;
        end
    end

    // Word leaves the last slot, zero when no read is due
    assign bus.rdata = rd_vld_q[LAT-1] ? store[rd_addr_q[LAT-1]] : '0;

endmodule

`default_nettype wire

// File: design/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// Controller to main memory, word addressed
interface mem_if;

    logic [`CACHE_ADDR_W-2:0] addr;
    logic [`CACHE_WORD_W-1:0] wdata;
    logic                     rd;
    logic                     wr;
    // Data for the read issued CACHE_MEM_LATENCY cycles earlier
    logic [`CACHE_WORD_W-1:0] rdata;

    modport master (output addr, output wdata, output rd, output wr, input rdata);

    modport slave (input addr, input wdata, input rd, input wr, output rdata);

endinterface

`default_nettype wire

// File: verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

// Table-driven testbench for the direct mapped cache
module cache_tb
    import cache_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 14;
    localparam int CYCLES_PER_TEST = 16;
    // Longest request is a dirty write miss, done 12 cycles in
    localparam int MAX_WAIT        = 16;
    localparam bit RD              = 1'b0;
    localparam bit WR              = 1'b1;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     rd;
    logic                     wr;
    logic [`CACHE_ADDR_W-1:0] addr;
    word_t                    wdata;
    word_t                    rdata;
    logic                     done;
    logic                     stall;
    logic                     cache_hit;

    // Stimulus table, one column per field
    string                    tbl_name    [NUM_TESTS];
    bit                       tbl_write   [NUM_TESTS];
    logic [`CACHE_ADDR_W-1:0] tbl_addr    [NUM_TESTS];
    word_t                    tbl_wdata   [NUM_TESTS];
    word_t                    tbl_rdata   [NUM_TESTS];
    bit                       tbl_hit     [NUM_TESTS];
    // Cycles from the request cycle to done
    int                       tbl_latency [NUM_TESTS];
    int                       table_len;

    int test_errors;
    int pass_count;
    int fail_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top u_cache_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    task automatic add_entry(input string name, input bit is_write,
                             input logic [`CACHE_ADDR_W-1:0] a, input word_t wd,
                             input word_t exp_rd, input bit exp_hit, input int latency);
        tbl_name[table_len]    = name;
        tbl_write[table_len]   = is_write;
        tbl_addr[table_len]    = a;
        tbl_wdata[table_len]   = wd;
        tbl_rdata[table_len]   = exp_rd;
        tbl_hit[table_len]     = exp_hit;
        tbl_latency[table_len] = latency;
        table_len++;
    endtask

    // Hit 0 cycles, clean read miss 7, clean write miss 8, dirty victim adds 4
    task automatic load_table();
        add_entry("rd_untouched",      RD, 16'h0400, 16'h0000, 16'h0000, 1'b0, 7);
        add_entry("rd_untouched_hit",  RD, 16'h0400, 16'h0000, 16'h0000, 1'b1, 0);
        // A is tag 2, index 0x25, word 0
        add_entry("wr_miss_a",         WR, 16'h1128, 16'hbeef, 16'h0000, 1'b0, 8);
        add_entry("rd_hit_a",          RD, 16'h1128, 16'h0000, 16'hbeef, 1'b1, 0);
        add_entry("rd_hit_a_word1",    RD, 16'h112a, 16'h0000, 16'h0000, 1'b1, 0);
        add_entry("wr_hit_a",          WR, 16'h1128, 16'h1234, 16'h0000, 1'b1, 0);
        add_entry("wr_hit_a_word3",    WR, 16'h112e, 16'h5a5a, 16'h0000, 1'b1, 0);
        add_entry("rd_hit_a_new",      RD, 16'h1128, 16'h0000, 16'h1234, 1'b1, 0);
        // B is tag 7 on the same index, so dirty A goes back to memory first
        add_entry("rd_conflict_b",     RD, 16'h3928, 16'h0000, 16'h0000, 1'b0, 11);
        add_entry("rd_refill_a",       RD, 16'h1128, 16'h0000, 16'h1234, 1'b0, 7);
        add_entry("rd_refill_a_word3", RD, 16'h112e, 16'h0000, 16'h5a5a, 1'b1, 0);
        add_entry("wr_miss_b",         WR, 16'h392c, 16'h0f0f, 16'h0000, 1'b0, 8);
        add_entry("rd_dirty_a",        RD, 16'h1128, 16'h0000, 16'h1234, 1'b0, 11);
        add_entry("rd_refill_b",       RD, 16'h392c, 16'h0000, 16'h0f0f, 1'b0, 7);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %0h actual %0h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    // Issue one table entry and hold it until done
    task automatic run_test(input int t);
        int    cycles;
        bit    saw_stall;
        bit    got_done;
        word_t seen_rdata;
        logic  seen_hit;
        cycles     = 0;
        saw_stall  = 1'b0;
        got_done   = 1'b0;
        seen_rdata = '0;
        seen_hit   = 1'b0;
        rd    <= !tbl_write[t];
        wr    <= tbl_write[t];
        addr  <= tbl_addr[t];
        wdata <= tbl_wdata[t];
        while (!got_done && cycles < MAX_WAIT) begin
            @(posedge clk);
            if (stall) begin
                saw_stall = 1'b1;
            end
            if (done) begin
                // Results captured at the done edge
                got_done   = 1'b1;
                seen_rdata = rdata;
                seen_hit   = cache_hit;
            end else begin
                cycles++;
            end
        end
        // Request dropped in the cycle after done
        rd <= 1'b0;
        wr <= 1'b0;
        if (!got_done) begin
            $display("test %s: done did not arrive within %0d cycles", tbl_name[t], MAX_WAIT);
            test_errors++;
        end else begin
            check_value(tbl_name[t], "cycles to done", tbl_latency[t], cycles);
            check_value(tbl_name[t], "cache_hit", tbl_hit[t], seen_hit);
            if (!tbl_write[t]) begin
                check_value(tbl_name[t], "rdata", tbl_rdata[t], seen_rdata);
            end
            // Misses stall at some edge, hits never do
            check_value(tbl_name[t], "stall seen", !tbl_hit[t], saw_stall);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        rd          = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        wdata       = '0;
        table_len   = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < table_len; t++) begin
            test_errors = 0;
            // One idle cycle ahead of each request
            @(posedge clk);
            check_value(tbl_name[t], "stall while idle", 1'b0, stall);
            check_value(tbl_name[t], "done while idle", 1'b0, done);
            run_test(t);
            if (test_errors == 0) begin
                pass_count++;
                $display("test %s: ok", tbl_name[t]);
            end else begin
                fail_count++;
                $display("test %s: %0d mismatches", tbl_name[t], test_errors);
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed", table_len, pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Upper bound on the whole run
    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog: the test sequence did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
